// ==== Makefile ====
TOP := tb_fdiv

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f build.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000

lint:
	verilator --lint-only --timing --assert -Wall -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== build.f ====
+incdir+logic
logic/fdiv_pkg.sv
logic/fp_unpack.sv
logic/div_queue.sv
logic/recip_rom.sv
logic/quot_fix.sv
logic/newton_div.sv
logic/fdiv_unit.sv
testbench/fdiv_checker.sv
testbench/tb_fdiv.sv

// ==== logic/div_queue.sv ====
`timescale 1ns/1ps
`include "fdiv_defs.svh"

module div_queue
    import fdiv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req_valid,
    input  div_req_t req,
    output logic     req_ready,
    output logic     q_valid,
    output div_req_t q_req,
    input  logic     q_ready
);

    localparam int DEPTH = `FDIV_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    div_req_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign req_ready = (count != CNT_W'(DEPTH));
    assign q_valid   = (count != '0);
    assign q_req     = mem[rd_ptr];

    assign push = req_valid && req_ready;
    assign pop  = q_valid && q_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage.
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req;
        end
    end

endmodule

// ==== logic/fdiv_defs.svh ====
`ifndef FDIV_DEFS_SVH
`define FDIV_DEFS_SVH

// Operand and significand formats.
`define FDIV_OP_W        64
`define FDIV_SIG_W       53
`define FDIV_QUOT_W      57
`define FDIV_QUOT_SP_W   27
`define FDIV_EXP_W       12
`define FDIV_TAG_W       4

// Working reciprocal and shared multiplier.
`define FDIV_RECIP_W     58
`define FDIV_PROD_W      116

// Request queue.
`define FDIV_QUEUE_DEPTH 4

// Reciprocal seed table.
`define FDIV_ROM_AW      8
`define FDIV_ROM_W       8
`define FDIV_ROM_DEPTH   256

// Newton steps per format.
`define FDIV_ITER_DP     3
`define FDIV_ITER_SP     2
`define FDIV_ITER_W      2

`endif

// ==== logic/fdiv_pkg.sv ====
`include "fdiv_defs.svh"

package fdiv_pkg;

    typedef logic [`FDIV_SIG_W-1:0]          sig_t;
    typedef logic [`FDIV_QUOT_W-1:0]         quot_t;
    typedef logic signed [`FDIV_EXP_W-1:0]   exp_t;
    typedef logic [`FDIV_TAG_W-1:0]          tag_t;
    typedef logic [`FDIV_RECIP_W-1:0]        recip_t;

    // Raw request as seen at the unit input.
    typedef struct packed {
        logic [`FDIV_OP_W-1:0] a;
        logic [`FDIV_OP_W-1:0] b;
        logic                  db;
        tag_t                  tag;
    } fp_op_t;

    // Unpacked request, significands carry the hidden bit.
    typedef struct packed {
        sig_t ma;
        sig_t mb;
        logic db;
        logic sign;
        exp_t exp;
        tag_t tag;
    } div_req_t;

    typedef struct packed {
        quot_t fq;
        logic  sign;
        exp_t  exp;
        tag_t  tag;
    } div_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        SEED,
        NEWTON_MUL,
        NEWTON_CPL,
        NEWTON_UPD,
        QUOT_MUL,
        FIX,
        DONE
    } div_state_t;

endpackage

// ==== logic/fdiv_unit.sv ====
`timescale 1ns/1ps

module fdiv_unit
    import fdiv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     op_valid,
    input  fp_op_t   op,
    output logic     op_ready,
    output logic     rsp_valid,
    output div_rsp_t rsp,
    input  logic     rsp_ready
);

    logic     req_valid;
    logic     req_ready;
    div_req_t req;
    logic     q_valid;
    logic     q_ready;
    div_req_t q_req;

    fp_unpack u_unpack (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (op_valid),
        .op        (op),
        .op_ready  (op_ready),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready)
    );

    div_queue u_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req       (req),
        .req_ready (req_ready),
        .q_valid   (q_valid),
        .q_req     (q_req),
        .q_ready   (q_ready)
    );

    newton_div u_div (
        .clk       (clk),
        .rst_n     (rst_n),
        .q_valid   (q_valid),
        .q_req     (q_req),
        .q_ready   (q_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

endmodule

// ==== logic/fp_unpack.sv ====
`timescale 1ns/1ps
`include "fdiv_defs.svh"

module fp_unpack
    import fdiv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     op_valid,
    input  fp_op_t   op,
    output logic     op_ready,
    output logic     req_valid,
    output div_req_t req,
    input  logic     req_ready
);

    localparam exp_t BIAS_DP = exp_t'(1023);
    localparam exp_t BIAS_SP = exp_t'(127);
    localparam int   SP_PAD  = `FDIV_SIG_W - 24;

    logic     full;
    div_req_t nxt;

    // Accept when empty or when the held entry leaves this cycle.
    assign op_ready  = !full || req_ready;
    assign req_valid = full;

    always_comb begin
        nxt.db  = op.db;
        nxt.tag = op.tag;
        if (op.db) begin
            nxt.sign = op.a[63] ^ op.b[63];
            nxt.ma   = {1'b1, op.a[51:0]};
            nxt.mb   = {1'b1, op.b[51:0]};
            nxt.exp  = exp_t'({1'b0, op.a[62:52]}) - exp_t'({1'b0, op.b[62:52]}) + BIAS_DP;
        end else begin
            nxt.sign = op.a[31] ^ op.b[31];
            // Single fractions sit at the top of the significand.
            nxt.ma   = {1'b1, op.a[22:0], {SP_PAD{1'b0}}};
            nxt.mb   = {1'b1, op.b[22:0], {SP_PAD{1'b0}}};
            nxt.exp  = exp_t'({4'b0, op.a[30:23]}) - exp_t'({4'b0, op.b[30:23]}) + BIAS_SP;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (op_valid && op_ready) begin
            full <= 1'b1;
        end else if (req_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid && op_ready) begin
            req <= nxt;
        end
    end

endmodule

// ==== logic/newton_div.sv ====
`timescale 1ns/1ps
`include "fdiv_defs.svh"

module newton_div
    import fdiv_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     q_valid,
    input  div_req_t q_req,
    output logic     q_ready,
    output logic     rsp_valid,
    output div_rsp_t rsp,
    input  logic     rsp_ready
);

    localparam int RW     = `FDIV_RECIP_W;
    localparam int QW     = `FDIV_QUOT_W;
    localparam int ITER_W = `FDIV_ITER_W;
    localparam int PAD    = RW - `FDIV_SIG_W;
    // Top of the product that still carries value.
    localparam int TOP    = 2 * RW - 2;

    div_state_t               state;
    div_state_t               state_nxt;
    logic [ITER_W-1:0]        cnt;
    div_req_t                 cur;
    recip_t                   x;
    recip_t                   t;
    quot_t                    q_est;
    quot_t                    fq_r;
    quot_t                    fix_fq;
    recip_t                   mul_a;
    recip_t                   mul_b;
    logic [`FDIV_PROD_W-1:0]  prod;
    logic [`FDIV_ROM_W-1:0]   rom_data;

    recip_rom u_rom (
        .addr (cur.mb[`FDIV_SIG_W-2 -: `FDIV_ROM_AW]),
        .data (rom_data)
    );

    quot_fix u_fix (
        .ma    (cur.ma),
        .mb    (cur.mb),
        .db    (cur.db),
        .q_est (q_est),
        .fq    (fix_fq)
    );

    // Shared multiplier, all operands scaled by 2^57.
    always_comb begin
        case (state)
            NEWTON_UPD: mul_a = t;
            QUOT_MUL:   mul_a = {cur.ma, {PAD{1'b0}}};
            default:    mul_a = {cur.mb, {PAD{1'b0}}};
        endcase
        mul_b = x;
    end

    assign prod = mul_a * mul_b;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:       if (q_valid) state_nxt = SEED;
            SEED:       state_nxt = NEWTON_MUL;
            NEWTON_MUL: state_nxt = NEWTON_CPL;
            NEWTON_CPL: state_nxt = NEWTON_UPD;
            NEWTON_UPD: state_nxt = (cnt == ITER_W'(1)) ? QUOT_MUL : NEWTON_MUL;
            QUOT_MUL:   state_nxt = FIX;
            FIX:        state_nxt = DONE;
            DONE:       if (rsp_ready) state_nxt = IDLE;
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            state <= state_nxt;
            if (state == SEED) begin
                cnt <= cur.db ? ITER_W'(`FDIV_ITER_DP) : ITER_W'(`FDIV_ITER_SP);
            end else if (state == NEWTON_UPD) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            IDLE:       if (q_valid) cur <= q_req;
            // Seed is 0.1 followed by the table bits.
            SEED:       x <= {2'b01, rom_data, {(RW - 2 - `FDIV_ROM_W){1'b0}}};
            NEWTON_MUL: t <= prod[TOP -: RW];
            // 2 - mb*x, one lsb low so x stays below 1/mb.
            NEWTON_CPL: t <= ~t;
            NEWTON_UPD: x <= prod[TOP -: RW];
            QUOT_MUL:   q_est <= prod[TOP -: QW];
            FIX:        fq_r <= fix_fq;
            default:    ;
        endcase
    end

    assign q_ready   = (state == IDLE);
    assign rsp_valid = (state == DONE);

    assign rsp.fq   = fq_r;
    assign rsp.sign = cur.sign;
    assign rsp.exp  = cur.exp;
    assign rsp.tag  = cur.tag;

endmodule

// ==== logic/quot_fix.sv ====
`timescale 1ns/1ps
`include "fdiv_defs.svh"

module quot_fix
    import fdiv_pkg::*;
(
    input  sig_t  ma,
    input  sig_t  mb,
    input  logic  db,
    input  quot_t q_est,
    output quot_t fq
);

    localparam int RW    = `FDIV_RECIP_W;
    localparam int QW    = `FDIV_QUOT_W;
    localparam int SP_W  = `FDIV_QUOT_SP_W;
    localparam int SP_LO = QW - SP_W;

    logic [RW-1:0]   mb_w;
    logic [RW-1:0]   r_dp;
    logic [RW-1:0]   r_sp;
    logic [RW-1:0]   rem;
    logic [SP_W-1:0] q_sp;
    logic [1:0]      corr;

    assign mb_w = RW'(mb);
    assign q_sp = q_est[QW-1 -: SP_W];

    // The remainder is below 3*mb, so low bits of the products suffice.
    assign r_dp = (RW'(ma) << (QW - 1)) - RW'(q_est) * mb_w;
    assign r_sp = (RW'(ma) << (SP_W - 1)) - RW'(q_sp) * mb_w;
    assign rem  = db ? r_dp : r_sp;

    always_comb begin
        if (rem >= (mb_w << 1)) begin
            corr = 2'd2;
        end else if (rem >= mb_w) begin
            corr = 2'd1;
        end else begin
            corr = 2'd0;
        end
    end

    assign fq = db ? q_est + QW'(corr) : {q_sp + SP_W'(corr), {SP_LO{1'b0}}};

endmodule

// ==== logic/recip_rom.sv ====
`timescale 1ns/1ps
`include "fdiv_defs.svh"

module recip_rom (
    input  logic [`FDIV_ROM_AW-1:0] addr,
    output logic [`FDIV_ROM_W-1:0]  data
);

    // Fraction bits after 0.1 of 1/(1.addr), taken at the interval midpoint.
    function automatic logic [`FDIV_ROM_W-1:0] seed_val(input int a);
        int den;
        int q;
        den = 513 + 2 * a;
        q   = (2 * 262144 + den) / (2 * den);
        if (q - 256 > 255) begin
            return 8'hff;
        end
        return 8'(q - 256);
    endfunction

    logic [`FDIV_ROM_W-1:0] rom [`FDIV_ROM_DEPTH];

    for (genvar i = 0; i < `FDIV_ROM_DEPTH; i++) begin : g_rom
        assign rom[i] = seed_val(i);
    end

    assign data = rom[addr];

endmodule

// ==== testbench/fdiv_checker.sv ====
`timescale 1ns/1ps

module fdiv_checker
    import fdiv_pkg::*;
(
    input logic     clk,
    input logic     rst_n,
    input logic     op_ready,
    input logic     q_valid,
    input logic     q_ready,
    input div_req_t q_req,
    input logic     rsp_valid,
    input logic     rsp_ready,
    input div_rsp_t rsp
);

    int   fail_count = 0;
    logic accept;

    assign accept = q_valid && q_ready;

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !rsp_valid && !q_valid)
        else begin
            fail_count++;
            $error("rsp_valid or q_valid is high during reset");
        end

    a_ready_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> op_ready)
        else begin
            fail_count++;
            $error("op_ready is low right after reset");
        end

    // A held response must not change.
    a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
        else begin
            fail_count++;
            $error("rsp changed or rsp_valid dropped while waiting for rsp_ready");
        end

    a_dp_early: assert property (@(posedge clk) disable iff (!rst_n)
        accept && q_req.db |-> ##12 !rsp_valid)
        else begin
            fail_count++;
            $error("double result arrived before 13 cycles");
        end

    a_dp_on_time: assert property (@(posedge clk) disable iff (!rst_n)
        accept && q_req.db |-> ##13 rsp_valid)
        else begin
            fail_count++;
            $error("double result missing 13 cycles after acceptance");
        end

    a_sp_early: assert property (@(posedge clk) disable iff (!rst_n)
        accept && !q_req.db |-> ##9 !rsp_valid)
        else begin
            fail_count++;
            $error("single result arrived before 10 cycles");
        end

    a_sp_on_time: assert property (@(posedge clk) disable iff (!rst_n)
        accept && !q_req.db |-> ##10 rsp_valid)
        else begin
            fail_count++;
            $error("single result missing 10 cycles after acceptance");
        end

endmodule

bind fdiv_unit fdiv_checker chk_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_ready  (op_ready),
    .q_valid   (q_valid),
    .q_ready   (q_ready),
    .q_req     (q_req),
    .rsp_valid (rsp_valid),
    .rsp_ready (rsp_ready),
    .rsp       (rsp)
);

// ==== testbench/tb_fdiv.sv ====
`timescale 1ns/1ps
`include "fdiv_defs.svh"

module tb_fdiv
    import fdiv_pkg::*;
();

    localparam int TIMEOUT = 200;

    logic     clk;
    logic     rst_n;
    logic     op_valid;
    fp_op_t   op;
    logic     op_ready;
    logic     rsp_valid;
    div_rsp_t rsp;
    logic     rsp_ready;
    integer   seed;
    tag_t     next_tag;
    int       sent;
    int       received;
    logic     bp_random;
    div_rsp_t exp_q [$];

    fdiv_unit dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (op_valid),
        .op        (op),
        .op_ready  (op_ready),
        .rsp_valid (rsp_valid),
        .rsp       (rsp),
        .rsp_ready (rsp_ready)
    );

    always #20 clk = ~clk;

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] want);
        assert (got === want) else begin
            fail_now($sformatf("Fail at %0t ns: %s expected %h, got %h",
                               $time, name, want, got));
        end
    endtask

    function automatic logic [63:0] pack_double(input logic s, input logic [10:0] e,
                                                input logic [51:0] f);
        return {s, e, f};
    endfunction

    function automatic logic [63:0] pack_single(input logic s, input logic [7:0] e,
                                                input logic [22:0] f);
        return {32'b0, s, e, f};
    endfunction

    // Exponents stay near the bias so the difference never wraps.
    function automatic logic [63:0] rand_double();
        logic [63:0] v;
        v        = {$random(seed), $random(seed)};
        v[62:52] = 11'(623 + $unsigned($random(seed)) % 800);
        return v;
    endfunction

    function automatic logic [63:0] rand_single();
        logic [63:0] v;
        v        = {32'b0, $random(seed)};
        v[30:23] = 8'(77 + $unsigned($random(seed)) % 100);
        return v;
    endfunction

    // Exact truncated quotient from the operand fields.
    function automatic div_rsp_t expected_result(input fp_op_t o);
        logic [127:0] num;
        logic [127:0] den;
        logic [127:0] q;
        div_rsp_t     r;
        if (o.db) begin
            num    = 128'({1'b1, o.a[51:0]}) << 56;
            den    = 128'({1'b1, o.b[51:0]});
            r.fq   = quot_t'(num / den);
            r.sign = o.a[63] ^ o.b[63];
            r.exp  = exp_t'(int'(o.a[62:52]) - int'(o.b[62:52]) + 1023);
        end else begin
            num    = 128'({1'b1, o.a[22:0]}) << 26;
            den    = 128'({1'b1, o.b[22:0]});
            q      = num / den;
            r.fq   = {q[26:0], 30'b0};
            r.sign = o.a[31] ^ o.b[31];
            r.exp  = exp_t'(int'(o.a[30:23]) - int'(o.b[30:23]) + 127);
        end
        r.tag = o.tag;
        return r;
    endfunction

    // Called 1 ns after a rising edge; returns 1 ns after the transfer edge.
    task automatic send_op(input logic db, input logic [63:0] a, input logic [63:0] b);
        fp_op_t o;
        int     waited;
        logic   taken;
        o.a      = a;
        o.b      = b;
        o.db     = db;
        o.tag    = next_tag;
        next_tag = next_tag + 1'b1;
        op       = o;
        op_valid = 1'b1;
        waited   = 0;
        taken    = 1'b0;
        while (!taken) begin
            taken = op_ready;
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                fail_now("Timeout: the unit never accepted a request.");
            end
        end
        op_valid = 1'b0;
        exp_q.push_back(expected_result(o));
        sent++;
    endtask

    task automatic send_random(input logic db);
        if (db) begin
            send_op(1'b1, rand_double(), rand_double());
        end else begin
            send_op(1'b0, rand_single(), rand_single());
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (received != sent) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                fail_now("Timeout: results were still missing after all requests were sent.");
            end
        end
    endtask

    // Holds rsp_ready low until the input side backs up, then lets results go.
    task automatic hold_until_stall();
        int waited;
        waited = 0;
        while (op_ready) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > TIMEOUT) begin
                fail_now("Timeout: op_ready never fell while results were held back.");
            end
        end
        repeat (6) @(posedge clk);
        #1;
        rsp_ready = 1'b1;
    endtask

    // Results are sampled mid-cycle and transfer at the next edge.
    always @(negedge clk) begin
        div_rsp_t want;
        if (rst_n && rsp_valid && rsp_ready) begin
            if (exp_q.size() == 0) begin
                fail_now("A result came out with no request outstanding.");
            end else begin
                want = exp_q.pop_front();
                compare_field("rsp.tag", 64'(rsp.tag), 64'(want.tag));
                compare_field("rsp.sign", 64'(rsp.sign), 64'(want.sign));
                compare_field("rsp.exp", 64'(rsp.exp), 64'(want.exp));
                compare_field("rsp.fq", 64'(rsp.fq), 64'(want.fq));
                received++;
            end
        end
    end

    always @(posedge clk) begin
        #1;
        if (bp_random) begin
            rsp_ready = ($random(seed) & 3) != 0;
        end
    end

    initial begin
        seed      = 32'hf01dc1a3;
        clk       = 1'b0;
        rst_n     = 1'b0;
        op_valid  = 1'b0;
        op        = '0;
        rsp_ready = 1'b1;
        bp_random = 1'b0;
        next_tag  = '0;
        sent      = 0;
        received  = 0;
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;

        // Edge significands and table corners 0x00 and 0xFF.
        send_op(1'b1, pack_double(1'b0, 11'd1023, '0), pack_double(1'b0, 11'd1023, '0));
        send_op(1'b1, pack_double(1'b1, 11'd1100, '1), pack_double(1'b0, 11'd1023, '0));
        send_op(1'b1, pack_double(1'b0, 11'd1023, '1), pack_double(1'b1, 11'd1023, '1));
        send_op(1'b1, pack_double(1'b0, 11'd1000, '0), pack_double(1'b0, 11'd1050, '1));
        send_op(1'b1, pack_double(1'b1, 11'd1023, '1), pack_double(1'b1, 11'd900, 52'h1));
        send_op(1'b0, pack_single(1'b0, 8'd127, '0), pack_single(1'b0, 8'd127, '0));
        send_op(1'b0, pack_single(1'b0, 8'd140, '1), pack_single(1'b1, 8'd127, '0));
        send_op(1'b0, pack_single(1'b1, 8'd100, '1), pack_single(1'b0, 8'd127, '1));
        send_op(1'b0, pack_single(1'b0, 8'd127, 23'h1234), pack_single(1'b0, 8'd120, 23'h7f8000));
        send_op(1'b0, pack_single(1'b0, 8'd127, '0), pack_single(1'b0, 8'd130, 23'h7fff));
        wait_drain();

        bp_random = 1'b1;
        for (int i = 0; i < 40; i++) begin
            send_random(1'b1);
            send_random(1'b0);
        end
        wait_drain();
        bp_random = 1'b0;

        // Burst longer than the queue with results held back.
        rsp_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < `FDIV_QUEUE_DEPTH + 6; i++) begin
                    send_random(1'(i % 2));
                end
            end
            hold_until_stall();
        join
        wait_drain();

        if (dut_i.chk_i.fail_count != 0) begin
            fail_now("The protocol checker reported an assertion failure.");
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule
